// ==== logic/segre_mem_pkg.sv ====
`default_nettype none

package segre_mem_pkg;

    localparam int WORD_WIDTH = 32;

    // Byte address into main memory
    typedef logic [WORD_WIDTH-1:0] addr_t;

    // Data or instruction word as seen on the memory port
    typedef logic [WORD_WIDTH-1:0] data_t;

endpackage : segre_mem_pkg

`default_nettype wire

// ==== logic/segre_pkg.sv ====
`default_nettype none

package segre_pkg;

    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 32;
    localparam int INSTR_WIDTH    = 32;
    localparam int INSTR_BYTES    = 4;

    // First fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // funct3 codes of the supported instructions
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [INSTR_WIDTH-1:0]    instr_t;

    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        PASS_B
    } alu_op_e;

    // Execute waits in MEM_WAIT for the data port
    typedef enum logic {
        IDLE,
        MEM_WAIT
    } ex_state_e;

endpackage : segre_pkg

`default_nettype wire

// ==== logic/segre_mem_if.sv ====
`default_nettype none

interface segre_mem_if
    import segre_mem_pkg::*;
();

    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    data_t rdata;
    logic  rdy;

    // Request fields stay stable until the rdy cycle
    modport requester (
        output req, we, addr, wdata,
        input  rdata, rdy
    );

    modport unit (
        input  req, we, addr, wdata,
        output rdata, rdy
    );

endinterface : segre_mem_if

`default_nettype wire

// ==== logic/segre_issue_if.sv ====
`default_nettype none

interface segre_issue_if
    import segre_pkg::*;
    import segre_mem_pkg::*;
();

    logic      valid;
    logic      ready;
    alu_op_e   alu_op;
    data_t     operand_a;
    data_t     operand_b;
    data_t     store_data;
    reg_addr_t rd;
    logic      rf_we;
    logic      mem_rd;
    logic      mem_wr;
    logic      is_branch;
    addr_t     branch_target;

    modport source (
        output valid, alu_op, operand_a, operand_b, store_data, rd, rf_we,
               mem_rd, mem_wr, is_branch, branch_target,
        input  ready
    );

    modport sink (
        input  valid, alu_op, operand_a, operand_b, store_data, rd, rf_we,
               mem_rd, mem_wr, is_branch, branch_target,
        output ready
    );

endinterface : segre_issue_if

`default_nettype wire

// ==== logic/segre_if_stage.sv ====
`default_nettype none

module segre_if_stage
    import segre_pkg::*;
    import segre_mem_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_i,
    segre_mem_if.requester fetch_o,
    output instr_t         instr_o,
    output addr_t          pc_o,
    output logic           valid_o,
    input  logic           ready_i,
    input  logic           redirect_i,
    input  addr_t          redirect_pc_i
);

    addr_t  pc_q;
    logic   req_q;
    logic   drop_q;
    logic   buf_valid_q;
    instr_t buf_instr_q;
    addr_t  buf_pc_q;
    addr_t  redirect_pc_q;
    logic   outstanding;

    assign fetch_o.req   = req_q;
    assign fetch_o.we    = 1'b0;
    assign fetch_o.addr  = pc_q;
    assign fetch_o.wdata = '0;

    assign instr_o = buf_instr_q;
    assign pc_o    = buf_pc_q;
    assign valid_o = buf_valid_q;

    // A fetch that is already on the bus cannot be pulled back
    assign outstanding = req_q && !fetch_o.rdy;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q        <= RESET_PC;
            req_q       <= 1'b0;
            drop_q      <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            // Keep one fetch in flight while the buffer is empty
            if (fetch_o.rdy) begin
                req_q <= 1'b0;
            end else if (!buf_valid_q) begin
                req_q <= 1'b1;
            end

            if (redirect_i) begin
                buf_valid_q <= 1'b0;
                drop_q      <= outstanding;
                if (!outstanding) begin
                    pc_q <= redirect_pc_i;
                end
            end else if (fetch_o.rdy) begin
                drop_q <= 1'b0;
                if (drop_q) begin
                    // Stale word, restart at the branch target
                    pc_q <= redirect_pc_q;
                end else begin
                    buf_valid_q <= 1'b1;
                    pc_q        <= pc_q + addr_t'(INSTR_BYTES);
                end
            end else if (buf_valid_q && ready_i) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_o.rdy) begin
            buf_instr_q <= fetch_o.rdata;
            buf_pc_q    <= pc_q;
        end
        if (redirect_i) begin
            redirect_pc_q <= redirect_pc_i;
        end
    end

endmodule : segre_if_stage

`default_nettype wire

// ==== logic/segre_id_stage.sv ====
`default_nettype none

module segre_id_stage
    import segre_pkg::*;
    import segre_mem_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_i,
    input  instr_t        instr_i,
    input  addr_t         pc_i,
    input  logic          valid_i,
    output logic          ready_o,
    input  logic          flush_i,
    output reg_addr_t     rf_raddr_a_o,
    output reg_addr_t     rf_raddr_b_o,
    input  data_t         rf_data_a_i,
    input  data_t         rf_data_b_i,
    segre_issue_if.source issue_o
);

    logic      valid_q;
    instr_t    instr_q;
    addr_t     pc_q;
    opcode_e   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    data_t     imm_i;
    data_t     imm_s;
    data_t     imm_b;
    data_t     imm_u;

    // Slot frees up in the cycle its instruction is accepted
    assign ready_o       = !valid_q || issue_o.ready;
    assign issue_o.valid = valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (valid_i && ready_o) begin
            valid_q <= 1'b1;
        end else if (issue_o.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            instr_q <= instr_i;
            pc_q    <= pc_i;
        end
    end

    assign opcode = opcode_e'(instr_q[6:0]);
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_u = {instr_q[31:12], 12'b0};

    // Operands are read here at issue, execute is idle so no bypass
    assign rf_raddr_a_o = instr_q[19:15];
    assign rf_raddr_b_o = instr_q[24:20];

    always_comb begin
        issue_o.alu_op        = ADD;
        issue_o.operand_a     = rf_data_a_i;
        issue_o.operand_b     = imm_i;
        issue_o.store_data    = rf_data_b_i;
        issue_o.rd            = instr_q[11:7];
        issue_o.rf_we         = 1'b0;
        issue_o.mem_rd        = 1'b0;
        issue_o.mem_wr        = 1'b0;
        issue_o.is_branch     = 1'b0;
        issue_o.branch_target = pc_q + imm_b;

        case (opcode)
            LUI: begin
                issue_o.alu_op    = PASS_B;
                issue_o.operand_b = imm_u;
                issue_o.rf_we     = 1'b1;
            end
            OP_IMM: begin
                // Only ADDI is supported
                issue_o.rf_we = (funct3 == F3_ADD);
            end
            OP: begin
                issue_o.operand_b = rf_data_b_i;
                issue_o.rf_we     = 1'b1;
                case (funct3)
                    F3_ADD:  issue_o.alu_op = funct7[5] ? SUB : ADD;
                    F3_XOR:  issue_o.alu_op = XOR;
                    F3_OR:   issue_o.alu_op = OR;
                    F3_AND:  issue_o.alu_op = AND;
                    default: issue_o.rf_we  = 1'b0;
                endcase
            end
            LOAD: begin
                issue_o.mem_rd = (funct3 == F3_WORD);
                issue_o.rf_we  = (funct3 == F3_WORD);
            end
            STORE: begin
                issue_o.operand_b = imm_s;
                issue_o.mem_wr    = (funct3 == F3_WORD);
            end
            BRANCH: begin
                // rs1 and rs2 go to execute for the compare
                issue_o.operand_b = rf_data_b_i;
                issue_o.is_branch = (funct3 == F3_BEQ);
            end
            default: begin
                // Anything else retires as a no-op
            end
        endcase
    end

endmodule : segre_id_stage

`default_nettype wire

// ==== logic/segre_ex_stage.sv ====
`default_nettype none

module segre_ex_stage
    import segre_pkg::*;
    import segre_mem_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_i,
    segre_issue_if.sink    issue_i,
    segre_mem_if.requester data_o,
    output logic           rf_we_o,
    output reg_addr_t      rf_waddr_o,
    output data_t          rf_wdata_o,
    output logic           redirect_o,
    output addr_t          redirect_pc_o
);

    ex_state_e state_q;
    logic      accept;
    logic      mem_op;
    data_t     alu_result;
    addr_t     mem_addr_q;
    logic      mem_we_q;
    data_t     mem_wdata_q;
    reg_addr_t load_rd_q;
    logic      load_we_q;

    assign issue_i.ready = (state_q == IDLE);
    assign accept        = issue_i.valid && issue_i.ready;
    assign mem_op        = issue_i.mem_rd || issue_i.mem_wr;

    always_comb begin
        case (issue_i.alu_op)
            SUB:     alu_result = issue_i.operand_a - issue_i.operand_b;
            AND:     alu_result = issue_i.operand_a & issue_i.operand_b;
            OR:      alu_result = issue_i.operand_a | issue_i.operand_b;
            XOR:     alu_result = issue_i.operand_a ^ issue_i.operand_b;
            PASS_B:  alu_result = issue_i.operand_b;
            default: alu_result = issue_i.operand_a + issue_i.operand_b;
        endcase
    end

    // BEQ resolves in the accept cycle
    assign redirect_o    = accept && issue_i.is_branch
                           && (issue_i.operand_a == issue_i.operand_b);
    assign redirect_pc_o = issue_i.branch_target;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:     if (accept && mem_op) state_q <= MEM_WAIT;
                MEM_WAIT: if (data_o.rdy) state_q <= IDLE;
                default:  state_q <= IDLE;
            endcase
        end
    end

    // Access fields held for the whole request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            mem_addr_q  <= alu_result;
            mem_we_q    <= issue_i.mem_wr;
            mem_wdata_q <= issue_i.store_data;
            load_rd_q   <= issue_i.rd;
            load_we_q   <= issue_i.rf_we;
        end
    end

    assign data_o.req   = (state_q == MEM_WAIT);
    assign data_o.we    = mem_we_q;
    assign data_o.addr  = mem_addr_q;
    assign data_o.wdata = mem_wdata_q;

    // ALU results write at the next edge, loads on the rdy edge
    always_comb begin
        if (state_q == MEM_WAIT) begin
            rf_we_o    = data_o.rdy && load_we_q;
            rf_waddr_o = load_rd_q;
            rf_wdata_o = data_o.rdata;
        end else begin
            rf_we_o    = accept && issue_i.rf_we && !issue_i.mem_rd;
            rf_waddr_o = issue_i.rd;
            rf_wdata_o = alu_result;
        end
    end

    // Decode must keep its instruction while the data access is pending
    a_issue_held_in_mem_wait: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (state_q == MEM_WAIT) && issue_i.valid |=> issue_i.valid
    ) else $error("decode dropped its instruction while execute waited on memory");

    a_data_req_held: assert property (
        @(posedge clk_i) disable iff (rst_i)
        data_o.req && !data_o.rdy |=> data_o.req && $stable(data_o.addr)
    ) else $error("data request dropped before rdy");

endmodule : segre_ex_stage

`default_nettype wire

// ==== logic/segre_register_file.sv ====
`default_nettype none

module segre_register_file
    import segre_pkg::*;
    import segre_mem_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output data_t     data_a_o,
    output data_t     data_b_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  data_t     wdata_i
);

    data_t regs [NUM_REGS];

    assign data_a_o = regs[raddr_a_i];
    assign data_b_o = regs[raddr_b_i];

    // x0 keeps its reset value
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    a_x0_reads_zero: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (raddr_a_i == '0) |-> (data_a_o == '0)
    ) else $error("x0 read back nonzero");

endmodule : segre_register_file

`default_nettype wire

// ==== logic/segre_mmu.sv ====
`default_nettype none

module segre_mmu
    import segre_mem_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    segre_mem_if.unit fetch_i,
    segre_mem_if.unit data_i,
    output logic      mm_rd_o,
    output logic      mm_wr_o,
    output addr_t     mm_addr_o,
    output addr_t     mm_wr_addr_o,
    output data_t     mm_wr_data_o,
    input  data_t     mm_rd_data_i,
    input  logic      mm_data_rdy_i
);

    logic grant_fetch_q;
    logic grant_data_q;
    logic idle;
    logic sel_fetch;
    logic sel_data;

    assign idle = !grant_fetch_q && !grant_data_q;

    // Data wins a tie, a grant is kept until main memory answers
    assign sel_data  = grant_data_q || (idle && data_i.req);
    assign sel_fetch = grant_fetch_q || (idle && !data_i.req && fetch_i.req);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grant_fetch_q <= 1'b0;
            grant_data_q  <= 1'b0;
        end else begin
            grant_fetch_q <= sel_fetch && !mm_data_rdy_i;
            grant_data_q  <= sel_data && !mm_data_rdy_i;
        end
    end

    assign mm_rd_o      = sel_fetch || (sel_data && !data_i.we);
    assign mm_wr_o      = sel_data && data_i.we;
    assign mm_addr_o    = sel_data ? data_i.addr : fetch_i.addr;
    assign mm_wr_addr_o = mm_addr_o;
    assign mm_wr_data_o = data_i.wdata;

    assign fetch_i.rdata = mm_rd_data_i;
    assign data_i.rdata  = mm_rd_data_i;
    assign fetch_i.rdy   = sel_fetch && mm_data_rdy_i;
    assign data_i.rdy    = sel_data && mm_data_rdy_i;

    a_rd_wr_exclusive: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(mm_rd_o && mm_wr_o)
    ) else $error("read and write raised together");

    a_addr_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (mm_rd_o || mm_wr_o) && !mm_data_rdy_i |=> $stable(mm_addr_o)
    ) else $error("main memory address changed during a pending request");

endmodule : segre_mmu

`default_nettype wire

// ==== logic/segre_core.sv ====
`default_nettype none

module segre_core
    import segre_pkg::*;
    import segre_mem_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    // Main memory
    input  logic  mm_data_rdy_i,
    input  data_t mm_rd_data_i,
    output data_t mm_wr_data_o,
    output addr_t mm_addr_o,
    output addr_t mm_wr_addr_o,
    output logic  mm_rd_o,
    output logic  mm_wr_o
);

    segre_mem_if   fetch_bus ();
    segre_mem_if   data_bus ();
    segre_issue_if issue_bus ();

    instr_t    fd_instr;
    addr_t     fd_pc;
    logic      fd_valid;
    logic      fd_ready;
    logic      redirect;
    addr_t     redirect_pc;
    reg_addr_t rf_raddr_a;
    reg_addr_t rf_raddr_b;
    data_t     rf_data_a;
    data_t     rf_data_b;
    logic      rf_we;
    reg_addr_t rf_waddr;
    data_t     rf_wdata;

    segre_if_stage if_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_o       (fetch_bus),
        .instr_o       (fd_instr),
        .pc_o          (fd_pc),
        .valid_o       (fd_valid),
        .ready_i       (fd_ready),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc)
    );

    segre_id_stage id_stage (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .instr_i      (fd_instr),
        .pc_i         (fd_pc),
        .valid_i      (fd_valid),
        .ready_o      (fd_ready),
        .flush_i      (redirect),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_data_a_i  (rf_data_a),
        .rf_data_b_i  (rf_data_b),
        .issue_o      (issue_bus)
    );

    segre_ex_stage ex_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_i       (issue_bus),
        .data_o        (data_bus),
        .rf_we_o       (rf_we),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    segre_register_file segre_rf (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .data_a_o  (rf_data_a),
        .data_b_o  (rf_data_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    segre_mmu mmu (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_i       (fetch_bus),
        .data_i        (data_bus),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o),
        .mm_addr_o     (mm_addr_o),
        .mm_wr_addr_o  (mm_wr_addr_o),
        .mm_wr_data_o  (mm_wr_data_o),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_data_rdy_i (mm_data_rdy_i)
    );

endmodule : segre_core

`default_nettype wire

// ==== testbench/segre_tb.sv ====
`default_nettype none

module segre_tb
    import segre_pkg::*;
    import segre_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 256;
    localparam int RUN_LIMIT = 4000;

    logic  clk_i;
    logic  rst_i;
    logic  mm_data_rdy_i;
    data_t mm_rd_data_i;
    data_t mm_wr_data_o;
    addr_t mm_addr_o;
    addr_t mm_wr_addr_o;
    logic  mm_rd_o;
    logic  mm_wr_o;

    // Main-memory model state
    data_t mem [MEM_WORDS];
    addr_t wr_addr_log[$];
    data_t wr_data_log[$];
    addr_t halt_pc;
    int    delay_mode;
    bit    busy;
    int    wait_cnt;
    int    halt_hits;
    bit    done;

    // Program image and expectations of the current test
    instr_t prog[$];
    addr_t  preset_addr[$];
    data_t  preset_data[$];
    addr_t  exp_addr[$];
    data_t  exp_data[$];

    segre_core UUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_wr_data_o  (mm_wr_data_o),
        .mm_addr_o     (mm_addr_o),
        .mm_wr_addr_o  (mm_wr_addr_o),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Stopping after the first failed check");
    endtask

    // RV32I encodings
    function automatic instr_t lui_word(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic instr_t itype_word(int imm, int rs1, logic [2:0] f3, int rd,
                                          logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic instr_t rtype_word(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                          int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic instr_t stype_word(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t btype_word(int off, int rs1, int rs2);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic data_t sign_extend12(int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    task automatic answer_request();
        int idx;
        idx = int'(mm_addr_o[31:2]);
        assert (mm_addr_o < addr_t'(MEM_WORDS * 4) && mm_addr_o[1:0] == 2'b00) else begin
            $display("Main memory access at %h falls outside the model or is unaligned",
                     mm_addr_o);
            abort_run();
        end
        if (mm_wr_o) begin
            assert (mm_wr_addr_o == mm_addr_o) else begin
                $display("ERROR %0t ns: mm_wr_addr_o = %h, expected %h",
                         $time, mm_wr_addr_o, mm_addr_o);
                abort_run();
            end
            mem[idx] = mm_wr_data_o;
            wr_addr_log.push_back(mm_addr_o);
            wr_data_log.push_back(mm_wr_data_o);
            halt_hits = 0;
        end else begin
            mm_rd_data_i <= mem[idx];
            // Two fetches of the halt loop with no store between ends the run
            if (mm_addr_o == halt_pc) begin
                halt_hits++;
                if (halt_hits >= 2) begin
                    done = 1'b1;
                end
            end
        end
        mm_data_rdy_i <= 1'b1;
    endtask

    always @(negedge clk_i) begin
        if (rst_i) begin
            mm_data_rdy_i <= 1'b0;
            busy = 1'b0;
            halt_hits = 0;
            done = 1'b0;
            wr_addr_log.delete();
            wr_data_log.delete();
        end else if (mm_data_rdy_i) begin
            mm_data_rdy_i <= 1'b0;
        end else if (mm_rd_o || mm_wr_o) begin
            if (!busy) begin
                busy = 1'b1;
                wait_cnt = (delay_mode != 0) ? int'($urandom % 8) : 1;
            end
            if (wait_cnt == 0) begin
                answer_request();
                busy = 1'b0;
            end else begin
                wait_cnt--;
            end
        end
    end

    task automatic expect_store(addr_t a, data_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic clear_test();
        prog.delete();
        preset_addr.delete();
        preset_data.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    // Reset, load the image, then run until the halt loop
    task automatic run_program(int rand_delays);
        int cycles;
        @(negedge clk_i);
        rst_i <= 1'b1;
        @(negedge clk_i);
        delay_mode = rand_delays;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hC0DE_0000 | data_t'(i * 4);
        end
        foreach (prog[i]) begin
            mem[i] = prog[i];
        end
        foreach (preset_addr[i]) begin
            mem[preset_addr[i] >> 2] = preset_data[i];
        end
        halt_pc = addr_t'(4 * (prog.size() - 1));
        for (int k = 0; k < 5; k++) begin
            if (k > 0) begin
                @(negedge clk_i);
            end
            assert (!mm_rd_o && !mm_wr_o) else begin
                $display("Main memory request raised while reset is held");
                abort_run();
            end
        end
        rst_i <= 1'b0;

        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!(mm_rd_o || mm_wr_o) && cycles < 10);
        assert (mm_rd_o && !mm_wr_o) else begin
            $display("First request after reset is not a read");
            abort_run();
        end
        assert (mm_addr_o == RESET_PC) else begin
            $display("ERROR %0t ns: mm_addr_o = %h, expected %h", $time, mm_addr_o, RESET_PC);
            abort_run();
        end

        cycles = 0;
        while (!done && cycles < RUN_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        assert (done) else begin
            $display("Timeout: program never settled in its halt loop");
            abort_run();
        end
    endtask

    task automatic compare_log();
        assert (wr_addr_log.size() == exp_addr.size()) else begin
            $display("Write log holds %0d stores where %0d were expected",
                     wr_addr_log.size(), exp_addr.size());
            abort_run();
        end
        foreach (exp_addr[i]) begin
            assert (wr_addr_log[i] == exp_addr[i]) else begin
                $display("ERROR %0t ns: mm_wr_addr_o = %h, expected %h",
                         $time, wr_addr_log[i], exp_addr[i]);
                abort_run();
            end
            assert (wr_data_log[i] == exp_data[i]) else begin
                $display("ERROR %0t ns: mm_wr_data_o = %h, expected %h",
                         $time, wr_data_log[i], exp_data[i]);
                abort_run();
            end
        end
    endtask

    task automatic alu_test();
        data_t r1;
        data_t r2;
        data_t r3;
        clear_test();
        prog.push_back(lui_word(1, 20'h12345));
        prog.push_back(itype_word(12'h9A5, 0, 3'b000, 2, 7'b0010011));
        prog.push_back(itype_word(12'h678, 1, 3'b000, 3, 7'b0010011));
        prog.push_back(rtype_word(7'h00, 2, 3, 3'b000, 4));
        prog.push_back(rtype_word(7'h20, 2, 3, 3'b000, 5));
        prog.push_back(rtype_word(7'h00, 2, 3, 3'b111, 6));
        prog.push_back(rtype_word(7'h00, 2, 3, 3'b110, 7));
        prog.push_back(rtype_word(7'h00, 2, 3, 3'b100, 8));
        for (int k = 1; k <= 8; k++) begin
            prog.push_back(stype_word(32'h200 + 4 * (k - 1), k, 0));
        end
        prog.push_back(btype_word(0, 0, 0));
        r1 = 32'h12345 << 12;
        r2 = sign_extend12(12'h9A5);
        r3 = r1 + sign_extend12(12'h678);
        expect_store(32'h200, r1);
        expect_store(32'h204, r2);
        expect_store(32'h208, r3);
        expect_store(32'h20C, r3 + r2);
        expect_store(32'h210, r3 - r2);
        expect_store(32'h214, r3 & r2);
        expect_store(32'h218, r3 | r2);
        expect_store(32'h21C, r3 ^ r2);
        run_program(0);
        compare_log();
    endtask

    // Fixed delays first, then the same program with random latency
    task automatic load_test();
        data_t d0;
        data_t d1;
        data_t d2;
        data_t sum;
        clear_test();
        d0 = 32'h8000_0FF0;
        d1 = 32'h1234_5678;
        d2 = 32'h0F0F_F0F0;
        preset_addr = '{32'h300, 32'h304, 32'h308};
        preset_data = '{d0, d1, d2};
        prog.push_back(itype_word(12'h300, 0, 3'b010, 1, 7'b0000011));
        prog.push_back(itype_word(12'h304, 0, 3'b010, 2, 7'b0000011));
        prog.push_back(itype_word(12'h308, 0, 3'b010, 10, 7'b0000011));
        prog.push_back(itype_word(12'h123, 1, 3'b000, 1, 7'b0010011));
        prog.push_back(stype_word(12'h300, 1, 0));
        prog.push_back(rtype_word(7'h00, 10, 2, 3'b100, 3));
        prog.push_back(stype_word(12'h304, 3, 0));
        prog.push_back(rtype_word(7'h20, 2, 1, 3'b000, 4));
        prog.push_back(stype_word(12'h308, 4, 0));
        prog.push_back(btype_word(0, 0, 0));
        sum = d0 + sign_extend12(12'h123);
        expect_store(32'h300, sum);
        expect_store(32'h304, d1 ^ d2);
        expect_store(32'h308, sum - d1);
        run_program(0);
        compare_log();
        run_program(1);
        compare_log();
    endtask

    task automatic branch_test();
        clear_test();
        prog.push_back(itype_word(5, 0, 3'b000, 1, 7'b0010011));
        prog.push_back(itype_word(5, 0, 3'b000, 2, 7'b0010011));
        prog.push_back(itype_word(9, 0, 3'b000, 3, 7'b0010011));
        prog.push_back(btype_word(8, 1, 2));
        prog.push_back(stype_word(12'h240, 3, 0));
        prog.push_back(btype_word(8, 1, 3));
        prog.push_back(stype_word(12'h244, 1, 0));
        prog.push_back(stype_word(12'h248, 2, 0));
        prog.push_back(btype_word(0, 0, 0));
        expect_store(32'h244, 32'd5);
        expect_store(32'h248, 32'd5);
        run_program(0);
        foreach (wr_addr_log[i]) begin
            assert (wr_addr_log[i] != 32'h240) else begin
                $display("Store behind a taken branch reached memory");
                abort_run();
            end
        end
        compare_log();
    endtask

    task automatic zero_reg_test();
        clear_test();
        prog.push_back(itype_word(12'h055, 0, 3'b000, 0, 7'b0010011));
        prog.push_back(stype_word(12'h280, 0, 0));
        prog.push_back(itype_word(12'h02A, 0, 3'b000, 5, 7'b0010011));
        // custom-0 and AUIPC shaped words that target x5
        prog.push_back({12'h7FF, 5'd5, 3'b000, 5'd5, 7'b0001011});
        prog.push_back({20'hFFFFF, 5'd5, 7'b0010111});
        prog.push_back(stype_word(12'h284, 5, 0));
        prog.push_back(btype_word(0, 0, 0));
        expect_store(32'h280, 32'd0);
        expect_store(32'h284, 32'h2A);
        run_program(0);
        compare_log();
    endtask

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        mm_data_rdy_i = 1'b0;
        mm_rd_data_i = '0;
        delay_mode = 0;
        halt_pc = '0;
        void'($urandom(46));
        alu_test();
        load_test();
        branch_test();
        zero_reg_test();
        $display("Result: PASSED");
        $finish;
    end

endmodule : segre_tb

`default_nettype wire

// ==== files.f ====
logic/segre_mem_pkg.sv
logic/segre_pkg.sv
logic/segre_mem_if.sv
logic/segre_issue_if.sv
logic/segre_if_stage.sv
logic/segre_id_stage.sv
logic/segre_ex_stage.sv
logic/segre_register_file.sv
logic/segre_mmu.sv
logic/segre_core.sv
testbench/segre_tb.sv

// ==== Bender.yml ====
package:
  name: segre

sources:
  - logic/segre_mem_pkg.sv
  - logic/segre_pkg.sv
  - logic/segre_mem_if.sv
  - logic/segre_issue_if.sv
  - logic/segre_if_stage.sv
  - logic/segre_id_stage.sv
  - logic/segre_ex_stage.sv
  - logic/segre_register_file.sv
  - logic/segre_mmu.sv
  - logic/segre_core.sv
  - target: test
    files:
      - testbench/segre_tb.sv
